// ==== filelist.f ====
+incdir+.
aer_pkg.sv
pixel_event_latch.sv
pixel_level.sv
pixel_groups_l0.sv
group_arbiter_l1.sv
aer_event_encoder.sv
wb_event_port.sv
aer_readout_top.sv
tb_aer_checker.sv
tb_aer_readout.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_aer_readout \
    -f filelist.f -o tb_aer_readout > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_aer_readout > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation log holds no verdict"
    exit 1
fi
exit 0

// ==== tb_aer_readout.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module tb_aer_readout;

    localparam int AS      = `AER_ARRAY_SIZE;
    localparam int GS      = `AER_GROUP_SIZE;
    localparam int GPS     = AS / GS;
    localparam int NG      = GPS * GPS;
    localparam int N_EVT   = 1 + AS * AS + 5 * GS * GS + 2;    // events over all five tests
    localparam int TIMEOUT = N_EVT * 12 + 500;
    localparam logic [2:0] ADR_STATUS = 3'd0;
    localparam logic [2:0] ADR_EVENT  = 3'd4;

    logic clk;
    logic rst;
    logic [AS-1:0][AS-1:0][`AER_POLARITY-1:0] evt;
    logic [AS-1:0][AS-1:0][`AER_POLARITY-1:0] pulse_map;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [2:0] wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic wb_ack;
    int test_num;
    logic test_end;
    logic drained;
    logic order_chk;
    logic status_chk;
    int exp_count;
    int errors;
    int tests;
    int failed;
    int words;
    int cycles;
    int grp_pick [NG];
    int j;
    int tmp;
    int px;
    int py;
    int g;
    logic [31:0] rd;

    aer_readout_top u_aer_readout_top (
        .clk_i    (clk),
        .rst_i    (rst),
        .evt_i    (evt),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_wdat),
        .wb_dat_o (wb_rdat),
        .wb_ack_o (wb_ack)
    );

    tb_aer_checker u_checker (
        .clk_i        (clk),
        .rst_i        (rst),
        .evt_i        (evt),
        .wb_cyc_i     (wb_cyc),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_rdat_i    (wb_rdat),
        .wb_ack_i     (wb_ack),
        .test_num_i   (test_num),
        .test_end_i   (test_end),
        .drained_i    (drained),
        .order_chk_i  (order_chk),
        .status_chk_i (status_chk),
        .exp_count_i  (exp_count),
        .errors_o     (errors),
        .tests_o      (tests),
        .failed_o     (failed),
        .words_o      (words)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped: the tests did not finish within %0d cycles", TIMEOUT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    //----------------------------------------------------------------------
    // stimulus tasks
    //----------------------------------------------------------------------
    task automatic inject_events();
        @(posedge clk);
        evt <= pulse_map;    // one cycle pulse
        @(posedge clk);
        evt <= '0;
    endtask

    task automatic mark_group(input int grp);
        for (int r = 0; r < GS; r++) begin
            for (int c = 0; c < GS; c++) begin
                pulse_map[(grp / GPS) * GS + r][(grp % GPS) * GS + c] = 2'($urandom_range(3, 1));
            end
        end
    endtask

    task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_adr <= adr;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        data = wb_rdat;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic drain_events(input int n);
        int got;
        logic [31:0] d;
        got = 0;
        while (got < n) begin
            bus_read(ADR_EVENT, d);
            if (d[8]) got++;
        end
        bus_read(ADR_EVENT, d);    // nothing may be left behind
    endtask

    task automatic start_test(input int n, input logic ord, input logic stat, input int cnt);
        @(posedge clk);
        test_num   <= n;
        order_chk  <= ord;
        status_chk <= stat;
        exp_count  <= cnt;
    endtask

    task automatic finish_test(input logic all_read);
        @(posedge clk);
        drained  <= all_read;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        rst        = 1'b1;
        evt        = '0;
        pulse_map  = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_wdat    = '0;
        test_num   = 0;
        test_end   = 1'b0;
        drained    = 1'b0;
        order_chk  = 1'b0;
        status_chk = 1'b0;
        exp_count  = 0;
        void'($urandom(32'h26c6_0624));
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        start_test(1, 1'b0, 1'b1, 0);
        bus_read(ADR_STATUS, rd);
        bus_read(ADR_EVENT, rd);
        bus_read(ADR_STATUS, rd);
        finish_test(1'b1);

        start_test(2, 1'b0, 1'b0, 0);
        px = int'($urandom_range(AS - 1, 0));
        py = int'($urandom_range(AS - 1, 0));
        pulse_map = '0;
        pulse_map[py][px][$urandom_range(1, 0)] = 1'b1;
        inject_events();
        drain_events(1);
        finish_test(1'b1);

        start_test(3, 1'b1, 1'b0, 0);
        for (int r = 0; r < AS; r++) begin
            for (int c = 0; c < AS; c++) begin
                pulse_map[r][c] = 2'($urandom_range(3, 1));
            end
        end
        inject_events();
        drain_events(AS * AS);
        finish_test(1'b1);

        // five whole groups, so grants come in runs long enough to fill the FIFO
        for (int i = 0; i < NG; i++) grp_pick[i] = i;
        for (int i = NG - 1; i > 0; i--) begin
            j = int'($urandom_range(i, 0));
            tmp         = grp_pick[i];
            grp_pick[i] = grp_pick[j];
            grp_pick[j] = tmp;
        end
        start_test(4, 1'b0, 1'b0, 0);
        pulse_map = '0;
        for (int k = 0; k < 5; k++) mark_group(grp_pick[k]);
        inject_events();
        rd = '0;
        while (!rd[5]) bus_read(ADR_STATUS, rd);
        start_test(4, 1'b0, 1'b1, `AER_FIFO_DEPTH);
        for (int k = 0; k < 3; k++) begin
            repeat (10) @(posedge clk);
            bus_read(ADR_STATUS, rd);
        end
        finish_test(1'b0);

        start_test(5, 1'b0, 1'b1, `AER_FIFO_DEPTH);
        g  = grp_pick[5];
        py = (g / GPS) * GS + int'($urandom_range(GS - 1, 0));
        px = (g % GPS) * GS + int'($urandom_range(GS - 1, 0));
        pulse_map = '0;
        pulse_map[py][px] = 2'b01;
        inject_events();
        repeat (4) @(posedge clk);
        pulse_map[py][px] = 2'b10;    // off event while the on event still waits
        inject_events();
        bus_read(ADR_STATUS, rd);
        @(posedge clk);
        status_chk <= 1'b0;
        drain_events(5 * GS * GS + 1);
        finish_test(1'b1);

        repeat (4) @(posedge clk);
        $display("tests %0d, failed %0d, words checked %0d, errors %0d",
                 tests, failed, words, errors);
        if (errors == 0 && failed == 0 && tests == 5) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_aer_checker.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module tb_aer_checker (
    input  logic clk_i,
    input  logic rst_i,
    input  logic [`AER_ARRAY_SIZE-1:0][`AER_ARRAY_SIZE-1:0][`AER_POLARITY-1:0] evt_i,
    input  logic wb_cyc_i,
    input  logic wb_we_i,
    input  logic [2:0] wb_adr_i,
    input  logic [31:0] wb_rdat_i,
    input  logic wb_ack_i,
    input  int test_num_i,
    input  logic test_end_i,
    input  logic drained_i,
    input  logic order_chk_i,
    input  logic status_chk_i,
    input  int exp_count_i,
    output int errors_o,
    output int tests_o,
    output int failed_o,
    output int words_o
);

    localparam int AS  = `AER_ARRAY_SIZE;
    localparam int GS  = `AER_GROUP_SIZE;
    localparam int GPS = AS / GS;
    localparam int NG  = GPS * GPS;

    logic [`AER_POLARITY-1:0] pend_model [AS][AS];    // indexed [y][x]
    int last_grp;
    logic in_grp;    // a group is being served and still has pixels left
    int test_errors;
    int test_words;

    function automatic int first_pending(input int g);
        int pos;
        pos = -1;
        for (int r = 0; r < GS; r++) begin
            for (int c = 0; c < GS; c++) begin
                if (pos < 0 && pend_model[(g / GPS) * GS + r][(g % GPS) * GS + c] != '0) begin
                    pos = ((g / GPS) * GS + r) * AS + (g % GPS) * GS + c;
                end
            end
        end
        return pos;
    endfunction

    // round robin over the groups, row-major inside the group in service
    function automatic int predict_next();
        int pos;
        int g;
        pos = in_grp ? first_pending(last_grp) : -1;
        for (int k = 1; k <= NG; k++) begin
            g = (last_grp + k) % NG;
            if (pos < 0) pos = first_pending(g);
        end
        return pos;
    endfunction

    function automatic string test_title(input int n);
        case (n)
            1:       return "reset state";
            2:       return "single event";
            3:       return "full array";
            4:       return "fifo full";
            5:       return "merge under stall";
            default: return "unnamed";
        endcase
    endfunction

    task automatic count_error();
        errors_o++;
        test_errors++;
    endtask

    task automatic check_event(input logic [31:0] d);
        int x;
        int y;
        int exp_pos;
        logic [`AER_POLARITY-1:0] exp_pol;
        x = int'(d[7:5]);
        y = int'(d[4:2]);
        if (!d[8]) begin
            if (d != '0) begin
                $display("** Error at %0d ns: wb_dat_o (empty read) expected %h, got %h",
                         $time, 32'h0, d);
                count_error();
            end
        end else begin
            test_words++;
            words_o++;
            if (order_chk_i) begin
                exp_pos = predict_next();
                if (exp_pos != y * AS + x) begin
                    $display("** Error at %0d ns: wb_dat_o pixel expected (%0d,%0d), got (%0d,%0d)",
                             $time, exp_pos % AS, exp_pos / AS, x, y);
                    count_error();
                end
            end
            exp_pol = pend_model[y][x];
            if (exp_pol == '0) begin
                $display("unexpected event from pixel (%0d,%0d) at %0d ns", x, y, $time);
                count_error();
            end else if (d[1:0] != exp_pol) begin
                $display("** Error at %0d ns: wb_dat_o.pol of pixel (%0d,%0d) expected %b, got %b",
                         $time, x, y, exp_pol, d[1:0]);
                count_error();
            end
            pend_model[y][x] = '0;
            last_grp = (y / GS) * GPS + x / GS;
            in_grp   = (first_pending(last_grp) >= 0);
        end
    endtask

    task automatic check_status(input logic [31:0] d);
        logic [31:0] exp;
        exp      = '0;
        exp[3:0] = 4'(exp_count_i);
        exp[4]   = (exp_count_i == 0);
        exp[5]   = (exp_count_i == `AER_FIFO_DEPTH);
        if (d !== exp) begin
            $display("** Error at %0d ns: wb_dat_o (status) expected %h, got %h", $time, exp, d);
            count_error();
        end
    endtask

    task automatic close_test();
        if (drained_i) begin
            for (int y = 0; y < AS; y++) begin
                for (int x = 0; x < AS; x++) begin
                    if (pend_model[y][x] != '0) begin
                        $display("pixel (%0d,%0d) was never read back", x, y);
                        count_error();
                        pend_model[y][x] = '0;
                    end
                end
            end
        end
        tests_o++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok, %0d words", test_num_i, test_title(test_num_i), test_words);
        end else begin
            $display("test %0d %s: FAILED with %0d errors", test_num_i, test_title(test_num_i),
                     test_errors);
            failed_o++;
        end
        test_errors = 0;
        test_words  = 0;
    endtask

    //----------------------------------------------------------------------
    // sampling happens on the clock edge, so all values are the settled ones
    //----------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_i) begin
            for (int y = 0; y < AS; y++) begin
                for (int x = 0; x < AS; x++) begin
                    pend_model[y][x] = '0;
                end
            end
            last_grp    = NG - 1;    // nothing served yet, group 0 comes first
            in_grp      = 1'b0;
            test_errors = 0;
            test_words  = 0;
            errors_o    = 0;
            tests_o     = 0;
            failed_o    = 0;
            words_o     = 0;
        end else begin
            for (int y = 0; y < AS; y++) begin
                for (int x = 0; x < AS; x++) begin
                    pend_model[y][x] = pend_model[y][x] | evt_i[y][x];    // events merge
                end
            end
            if (wb_ack_i && wb_cyc_i && !wb_we_i) begin
                if (wb_adr_i[2]) check_event(wb_rdat_i);
                else if (status_chk_i) check_status(wb_rdat_i);
            end
            if (test_end_i) close_test();
        end
    end

endmodule

// ==== aer_readout_top.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module aer_readout_top (
    input  logic clk_i,
    input  logic rst_i,
    input  logic [`AER_ARRAY_SIZE-1:0][`AER_ARRAY_SIZE-1:0][`AER_POLARITY-1:0] evt_i,
    input  logic wb_cyc_i,
    input  logic wb_stb_i,
    input  logic wb_we_i,
    input  logic [2:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic wb_ack_o
);

    localparam int AS  = `AER_ARRAY_SIZE;
    localparam int GPS = `AER_GROUPS_PER_SIDE;

    logic [AS-1:0][AS-1:0][`AER_POLARITY-1:0] pend;
    logic [AS-1:0][AS-1:0] gnt_pix;
    logic [GPS-1:0][GPS-1:0] grp_req;
    logic [GPS-1:0][GPS-1:0] gnt_top;
    logic [$clog2(`AER_NUM_GROUPS)-1:0] grp_idx;
    logic [$clog2(`AER_GROUP_SIZE)-1:0] x_add;
    logic [$clog2(`AER_GROUP_SIZE)-1:0] y_add;
    logic grp_release;
    logic active;
    logic stall;
    aer_pkg::aer_event_t evt_word;
    logic evt_valid;

    pixel_event_latch u_pixel_event_latch (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .evt_i  (evt_i),
        .gnt_i  (gnt_pix),
        .pend_o (pend)
    );

    pixel_groups_l0 u_pixel_groups_l0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .set_i         (pend),
        .gnt_top_i     (gnt_top),
        .req_o         (grp_req),
        .gnt_o_0       (gnt_pix),
        .grp_release_o (grp_release),
        .x_add_o       (x_add),
        .y_add_o       (y_add),
        .active_o      (active)
    );

    group_arbiter_l1 u_group_arbiter_l1 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (grp_req),
        .grp_release_i (grp_release),
        .stall_i       (stall),
        .gnt_top_o     (gnt_top),
        .grp_idx_o     (grp_idx)
    );

    aer_event_encoder u_aer_event_encoder (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .active_i    (active),
        .grp_idx_i   (grp_idx),
        .x_add_i     (x_add),
        .y_add_i     (y_add),
        .pend_i      (pend),
        .evt_o       (evt_word),
        .evt_valid_o (evt_valid)
    );

    wb_event_port u_wb_event_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .evt_i       (evt_word),
        .evt_valid_i (evt_valid),
        .stall_o     (stall),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o)
    );

endmodule

// ==== wb_event_port.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module wb_event_port (
    input  logic clk_i,
    input  logic rst_i,
    input  aer_pkg::aer_event_t evt_i,
    input  logic evt_valid_i,
    output logic stall_o,
    input  logic wb_cyc_i,
    input  logic wb_stb_i,
    input  logic wb_we_i,
    input  logic [2:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic wb_ack_o
);
    import aer_pkg::*;

    localparam int DEPTH = `AER_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    aer_event_t mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0] count;
    logic empty;
    logic full;
    logic bus_req;
    logic pop;
    wb_reg_e reg_sel;

    //----------------------------------------------------------------------
    // event FIFO
    //----------------------------------------------------------------------
    assign empty = (count == '0);
    assign full  = (count == (PW+1)'(DEPTH));

    // two free slots cover one grant in flight plus the encoder register
    assign stall_o = (count > (PW+1)'(DEPTH - 2));

    always_ff @(posedge clk_i) begin
        if (evt_valid_i) begin
            mem[wr_ptr] <= evt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (evt_valid_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PW+1)'(evt_valid_i) - (PW+1)'(pop);
        end
    end

    //----------------------------------------------------------------------
    // wishbone classic slave
    //----------------------------------------------------------------------
    assign bus_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign reg_sel = wb_reg_e'(wb_adr_i[2]);
    assign pop     = bus_req && !wb_we_i && (reg_sel == REG_EVENT) && !empty;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= bus_req;    // one cycle after the request, single cycle
        end
    end

    // read data is registered with the ack, writes read back as zero
    always_ff @(posedge clk_i) begin
        wb_dat_o <= '0;
        if (bus_req && !wb_we_i) begin
            if (reg_sel == REG_STATUS) begin
                wb_dat_o[3:0] <= count;
                wb_dat_o[4]   <= empty;
                wb_dat_o[5]   <= full;
            end else if (!empty) begin
                wb_dat_o[7:0] <= mem[rd_ptr];
                wb_dat_o[8]   <= 1'b1;
            end
        end
    end

endmodule

// ==== aer_event_encoder.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module aer_event_encoder (
    input  logic clk_i,
    input  logic rst_i,
    input  logic active_i,
    input  logic [$clog2(`AER_NUM_GROUPS)-1:0] grp_idx_i,
    input  logic [$clog2(`AER_GROUP_SIZE)-1:0] x_add_i,
    input  logic [$clog2(`AER_GROUP_SIZE)-1:0] y_add_i,
    input  logic [`AER_ARRAY_SIZE-1:0][`AER_ARRAY_SIZE-1:0][`AER_POLARITY-1:0] pend_i,
    output aer_pkg::aer_event_t evt_o,
    output logic evt_valid_o
);

    localparam int GW = $clog2(`AER_GROUPS_PER_SIDE);

    logic [GW-1:0] grp_col;
    logic [GW-1:0] grp_row;
    logic [`AER_ADDR_W-1:0] pix_x;
    logic [`AER_ADDR_W-1:0] pix_y;

    assign grp_col = grp_idx_i[GW-1:0];
    assign grp_row = grp_idx_i[2*GW-1:GW];

    // group side is a power of two, so base times size plus offset is a concatenation
    assign pix_x = {grp_col, x_add_i};
    assign pix_y = {grp_row, y_add_i};

    always_ff @(posedge clk_i) begin
        evt_o.x   <= pix_x;
        evt_o.y   <= pix_y;
        evt_o.pol <= pend_i[pix_y][pix_x];    // flags are still set during the grant cycle
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            evt_valid_o <= 1'b0;
        end else begin
            evt_valid_o <= active_i;
        end
    end

endmodule

// ==== group_arbiter_l1.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module group_arbiter_l1 (
    input  logic clk_i,
    input  logic rst_i,
    input  logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] req_i,
    input  logic grp_release_i,
    input  logic stall_i,
    output logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] gnt_top_o,
    output logic [$clog2(`AER_NUM_GROUPS)-1:0] grp_idx_o
);
    import aer_pkg::*;

    localparam int NG = `AER_NUM_GROUPS;
    localparam int IW = $clog2(NG);

    l1_state_e state_q;
    logic [IW-1:0] last_q;
    logic [IW-1:0] grp_q;
    logic [IW-1:0] cand;
    logic [IW-1:0] next_grp;
    logic [NG-1:0] req_flat;
    logic any_req;

    assign req_flat = req_i;    // bit index is row * 4 + col

    // search starts just after the last served group and wraps around
    always_comb begin
        any_req  = 1'b0;
        next_grp = '0;
        cand     = last_q;
        for (int k = 0; k < NG; k++) begin
            cand = cand + 1'b1;
            if (req_flat[cand] && !any_req) begin
                any_req  = 1'b1;
                next_grp = cand;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= L1_SCAN;
            last_q  <= IW'(NG - 1);    // first scan begins at group 0
            grp_q   <= '0;
        end else begin
            case (state_q)
                L1_SCAN: begin
                    if (any_req) begin
                        state_q <= L1_HOLD;
                        grp_q   <= next_grp;
                        last_q  <= next_grp;
                    end
                end
                L1_HOLD: if (grp_release_i) state_q <= L1_SCAN;
                default: state_q <= L1_SCAN;
            endcase
        end
    end

    // stall only masks the enable, the hold state is kept
    assign gnt_top_o = (state_q == L1_HOLD && !stall_i) ? NG'(1) << grp_q : '0;
    assign grp_idx_o = grp_q;

endmodule

// ==== pixel_groups_l0.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module pixel_groups_l0 (
    input  logic clk_i,
    input  logic rst_i,
    input  logic [`AER_ARRAY_SIZE-1:0][`AER_ARRAY_SIZE-1:0][`AER_POLARITY-1:0] set_i,
    input  logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] gnt_top_i,
    output logic [`AER_GROUPS_PER_SIDE-1:0][`AER_GROUPS_PER_SIDE-1:0] req_o,
    output logic [`AER_ARRAY_SIZE-1:0][`AER_ARRAY_SIZE-1:0] gnt_o_0,
    output logic grp_release_o,
    output logic [$clog2(`AER_GROUP_SIZE)-1:0] x_add_o,
    output logic [$clog2(`AER_GROUP_SIZE)-1:0] y_add_o,
    output logic active_o
);

    localparam int GS  = `AER_GROUP_SIZE;
    localparam int GPS = `AER_GROUPS_PER_SIDE;
    localparam int NG  = `AER_NUM_GROUPS;
    localparam int AW  = $clog2(GS);

    logic [NG-1:0][GS-1:0][GS-1:0][`AER_POLARITY-1:0] set_grp;
    logic [NG-1:0][GS-1:0][GS-1:0] gnt_grp;
    logic [NG-1:0][AW-1:0] x_add_grp;
    logic [NG-1:0][AW-1:0] y_add_grp;
    logic [NG-1:0] active_grp;
    logic [NG-1:0] release_grp;

    // group g covers rows (g / GPS) * GS and columns (g % GPS) * GS onward
    for (genvar g = 0; g < NG; g++) begin : groups
        for (genvar r = 0; r < GS; r++) begin : rows
            for (genvar c = 0; c < GS; c++) begin : cols
                assign set_grp[g][r][c] = set_i[(g / GPS) * GS + r][(g % GPS) * GS + c];
                assign gnt_o_0[(g / GPS) * GS + r][(g % GPS) * GS + c] = gnt_grp[g][r][c];
            end
        end

        pixel_level #(
            .GROUP_SIZE(GS)
        ) u_pixel_level (
            .clk_i         (clk_i),
            .rst_i         (rst_i),
            .enable_i      (gnt_top_i[g / GPS][g % GPS]),
            .req_i         (set_grp[g]),
            .req_o         (req_o[g / GPS][g % GPS]),
            .gnt_o         (gnt_grp[g]),
            .x_add_o       (x_add_grp[g]),
            .y_add_o       (y_add_grp[g]),
            .active_o      (active_grp[g]),
            .grp_release_o (release_grp[g])
        );
    end

    // at most one group is enabled, so a plain OR of the masked terms is enough
    always_comb begin
        x_add_o       = '0;
        y_add_o       = '0;
        active_o      = 1'b0;
        grp_release_o = 1'b0;
        for (int g = 0; g < NG; g++) begin
            if (gnt_top_i[g / GPS][g % GPS]) begin
                x_add_o       = x_add_o | x_add_grp[g];
                y_add_o       = y_add_o | y_add_grp[g];
                active_o      = active_o | active_grp[g];
                grp_release_o = grp_release_o | release_grp[g];
            end
        end
    end

endmodule

// ==== pixel_level.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module pixel_level #(
    parameter int GROUP_SIZE = 2
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic enable_i,
    input  logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0][`AER_POLARITY-1:0] req_i,
    output logic req_o,
    output logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] gnt_o,
    output logic [$clog2(GROUP_SIZE)-1:0] x_add_o,
    output logic [$clog2(GROUP_SIZE)-1:0] y_add_o,
    output logic active_o,
    output logic grp_release_o
);
    import aer_pkg::*;

    localparam int AW = $clog2(GROUP_SIZE);

    lvl_state_e state_q;
    lvl_state_e state_d;
    logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] pix_req;
    logic found;
    logic [AW-1:0] sel_x;
    logic [AW-1:0] sel_y;

    // first pending pixel in row-major order
    always_comb begin
        found = 1'b0;
        sel_x = '0;
        sel_y = '0;
        for (int r = 0; r < GROUP_SIZE; r++) begin
            for (int c = 0; c < GROUP_SIZE; c++) begin
                pix_req[r][c] = |req_i[r][c];
                if (pix_req[r][c] && !found) begin
                    found = 1'b1;
                    sel_y = AW'(r);
                    sel_x = AW'(c);
                end
            end
        end
    end

    assign req_o         = |pix_req;
    assign active_o      = (state_q == LVL_SERVE) && enable_i && found;
    assign grp_release_o = (state_q == LVL_RELEASE);
    assign x_add_o       = sel_x;
    assign y_add_o       = sel_y;

    always_comb begin
        gnt_o = '0;
        if (active_o) begin
            gnt_o[sel_y][sel_x] = 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // group FSM
    //----------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            LVL_IDLE:    if (enable_i) state_d = LVL_SERVE;
            LVL_SERVE:   if (enable_i && !found) state_d = LVL_RELEASE;  // stall keeps us here
            LVL_RELEASE: state_d = LVL_IDLE;
            default:     state_d = LVL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= LVL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== pixel_event_latch.sv ====
`timescale 1ns/1ps
`include "aer_config.svh"

module pixel_event_latch (
    input  logic clk_i,
    input  logic rst_i,
    input  logic [`AER_ARRAY_SIZE-1:0][`AER_ARRAY_SIZE-1:0][`AER_POLARITY-1:0] evt_i,
    input  logic [`AER_ARRAY_SIZE-1:0][`AER_ARRAY_SIZE-1:0]                     gnt_i,
    output logic [`AER_ARRAY_SIZE-1:0][`AER_ARRAY_SIZE-1:0][`AER_POLARITY-1:0] pend_o
);

    // a grant clears both polarity flags, a fresh event in the same cycle is kept
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_o <= '0;
        end else begin
            for (int r = 0; r < `AER_ARRAY_SIZE; r++) begin
                for (int c = 0; c < `AER_ARRAY_SIZE; c++) begin
                    pend_o[r][c] <= (pend_o[r][c] & ~{`AER_POLARITY{gnt_i[r][c]}})
                                    | evt_i[r][c];
                end
            end
        end
    end

endmodule

// ==== aer_pkg.sv ====
`include "aer_config.svh"

package aer_pkg;

    typedef enum logic [1:0] {
        LVL_IDLE,
        LVL_SERVE,
        LVL_RELEASE
    } lvl_state_e;

    typedef enum logic {
        L1_SCAN,
        L1_HOLD
    } l1_state_e;

    // decoded from wishbone address bit 2
    typedef enum logic {
        REG_STATUS = 1'b0,
        REG_EVENT  = 1'b1
    } wb_reg_e;

    typedef struct packed {
        logic [`AER_ADDR_W-1:0]   x;
        logic [`AER_ADDR_W-1:0]   y;
        logic [`AER_POLARITY-1:0] pol;    // bit 0 on, bit 1 off
    } aer_event_t;

endpackage

// ==== aer_config.svh ====
`ifndef AER_CONFIG_SVH
`define AER_CONFIG_SVH

// pixel array geometry
`define AER_ARRAY_SIZE      8
`define AER_GROUP_SIZE      2
`define AER_GROUPS_PER_SIDE 4
`define AER_NUM_GROUPS      16

// each pixel has an on line and an off line
`define AER_POLARITY        2
`define AER_ADDR_W          3

`define AER_FIFO_DEPTH      8

`endif
